// ==== Makefile ====
TOP := tb_ctl_top

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; false)
	cat sim.log
	! grep -q "Result: FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== ctl_array_model.sv ====
// Test array behavioral model

`timescale 1ns/100ps
`default_nettype none

module ctl_array_model
  import ctl_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  ra_port_t ra_port,
  output ra_rsp_t  ra_rsp
);

  // 32 rows, contents only defined once written
  ctl_data_t rows [32];
  ctl_data_t r0_q;
  ctl_data_t r1_q;
  ctl_data_t cfg_q;
  ctl_data_t status_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      r0_q     <= '0;
      r1_q     <= '0;
      cfg_q    <= '0;
      status_q <= '0;
    end else begin
      // port data registered at the edge, held until the next enable
      if (ra_port.r0_enb) begin
        r0_q <= rows[ra_port.r0_adr];
      end
      if (ra_port.r1_enb) begin
        r1_q <= rows[ra_port.r1_adr];
      end
      if (ra_port.w0_enb) begin
        rows[ra_port.w0_adr] <= ra_port.w0_dat;
      end
      if (ra_port.cfg_wr) begin
        cfg_q <= ra_port.cfg_wdat;
      end
      // status reports the last self-test word, inverted
      if (ra_port.bist_ctl != '0) begin
        status_q <= ~ra_port.bist_ctl;
      end
    end
  end

  always_comb begin
    ra_rsp.r0_dat      = r0_q;
    ra_rsp.r1_dat      = r1_q;
    ra_rsp.cfg_rdat    = cfg_q;
    ra_rsp.bist_status = status_q;
  end

endmodule

`default_nettype wire

// ==== ctl_cfg_regs.sv ====
// Controller configuration register

`timescale 1ns/100ps
`default_nettype none

module ctl_cfg_regs
  import ctl_pkg::*;
#(
  parameter ctl_data_t CFG0_INIT = 32'h0000_0001
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      cfg0_we,
  input  ctl_data_t cfg0_wdat,
  output ctl_data_t cfg0_q,
  output ctl_wait_t rd_wait
);

  // cfg0 layout
  //   31:3  reserved, stored and readable
  //   2:0   read wait cycles after the command cycle
  ctl_data_t cfg0_r;

  // whole word is stored so software sees what it wrote
  always_ff @(posedge clk) begin
    if (rst) begin
      cfg0_r <= CFG0_INIT;
    end else if (cfg0_we) begin
      cfg0_r <= cfg0_wdat;
    end
  end

  assign cfg0_q = cfg0_r;

  // only the low field steers the sequencer
  assign rd_wait = cfg0_r[CTL_WAIT_W-1:0];

endmodule

`default_nettype wire

// ==== ctl_checker.sv ====
// Sequencer handshake assertions

`timescale 1ns/100ps
`default_nettype none

module ctl_checker
  import ctl_pkg::*;
(
  input logic     clk,
  input logic     rst,
  input logic     rd_ack,
  input logic     busy,
  input ra_port_t ra_port
);

  logic any_enb;

  // any control that would touch the array
  assign any_enb = ra_port.r0_enb | ra_port.r1_enb | ra_port.w0_enb | ra_port.cfg_wr;

  // ack is a single-cycle pulse
  ack_one_cycle: assert property (@(posedge clk) disable iff (rst) rd_ack |=> !rd_ack)
    else $error("rd_ack high for two cycles");

  // sequencer back in idle right after its ack
  busy_after_ack: assert property (@(posedge clk) disable iff (rst) rd_ack |=> !busy)
    else $error("busy still high the cycle after rd_ack");

  // array left alone while in reset
  quiet_in_reset: assert property (@(posedge clk) rst |-> !any_enb)
    else $error("array port enable active during reset");

endmodule

`default_nettype wire

// ==== ctl_cmd_decode.sv ====
// Host command decoder

`timescale 1ns/100ps
`default_nettype none

module ctl_cmd_decode
  import ctl_pkg::*;
#(
  parameter logic [CTL_REGION_W-1:0] CFG_REGION  = 4'hE,
  parameter logic [CTL_REGION_W-1:0] BIST_REGION = 4'hF,
  parameter logic [CTL_OFFSET_W-1:0] CFG0_OFFSET = 12'h000
) (
  input  ctl_cmd_t    cmd,
  input  logic        busy,
  output ra_port_t    ra_port,
  output logic        cfg0_we,
  output ctl_data_t   cfg0_wdat,
  output logic        rd_start,
  output ctl_rd_src_e rd_src
);

  ctl_adr_u  adr;
  logic      is_cfg;
  logic      is_bist;
  logic      special;
  logic      ctl_wr;
  logic      ctl_rd;
  logic      ra_wr;
  logic      ra_rd;
  logic      ra_port_rd;
  logic [1:0] rd_type;

  assign adr = cmd.adr;

  // region view picks the special areas
  assign is_cfg  = (adr.rgn.region == CFG_REGION);
  assign is_bist = (adr.rgn.region == BIST_REGION);
  assign special = is_cfg | is_bist;

  // port view gives the read type
  assign rd_type = adr.prt.rd_type;

  // classify the strobe
  assign ctl_wr = cmd.ctl_val & cmd.we;
  assign ctl_rd = cmd.ctl_val & ~cmd.we;
  assign ra_wr  = cmd.ra_val & cmd.we;
  assign ra_rd  = cmd.ra_val & ~cmd.we;

  // array read that goes through the row ports, dropped while busy
  assign ra_port_rd = ra_rd & ~special & ~busy;

  // cfg0 lives outside the special regions
  assign cfg0_we   = ctl_wr & ~special & (adr.rgn.offset == CFG0_OFFSET);
  assign cfg0_wdat = cmd.dat;

  // one read in flight, a read arriving while busy is lost
  assign rd_start = (ctl_rd | ra_rd) & ~busy;

  // array port controls for this cycle
  always_comb begin
    ra_port = '0;
    // r0 serves types 00, 10 and 11
    ra_port.r0_enb = ra_port_rd & (rd_type != 2'b01);
    ra_port.r0_adr = adr.prt.r0_row;
    // r1 serves types 01, 10 and 11
    ra_port.r1_enb = ra_port_rd & (rd_type != 2'b00);
    // type 01 reads the r0 row through r1
    ra_port.r1_adr = (rd_type == 2'b01) ? adr.prt.r0_row : adr.prt.r1_row;
    // row writes only outside the special regions
    ra_port.w0_enb = ra_wr & ~special & cmd.sel[0];
    ra_port.w0_adr = adr.prt.r0_row;
    ra_port.w0_dat = cmd.dat;
    ra_port.cfg_wr   = ra_wr & is_cfg & ~is_bist;
    ra_port.cfg_wdat = cmd.dat;
    // self-test word is only nonzero in the write cycle
    if (ra_wr && is_bist) begin
      ra_port.bist_ctl = cmd.dat;
    end
  end

  // read source selection
  always_comb begin
    if (is_bist) begin
      rd_src = SRC_BIST;
    end else if (is_cfg) begin
      rd_src = SRC_ACFG;
    end else if (cmd.ctl_val) begin
      rd_src = SRC_CFG0;
    end else begin
      // plain array read, source by read type
      case (rd_type)
        2'b00:   rd_src = SRC_R0;
        2'b01:   rd_src = SRC_R1;
        2'b10:   rd_src = SRC_LO;
        default: rd_src = SRC_HI;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== ctl_pkg.sv ====
// Command controller shared types

`default_nettype none

package ctl_pkg;

  // controller widths
  localparam int CTL_DATA_W   = 32;
  localparam int CTL_ROW_W    = 5;
  localparam int CTL_WAIT_W   = 3;
  localparam int CTL_REGION_W = 4;
  localparam int CTL_OFFSET_W = 12;

  typedef logic [CTL_DATA_W-1:0] ctl_data_t;
  typedef logic [CTL_ROW_W-1:0]  ctl_row_t;
  typedef logic [CTL_WAIT_W-1:0] ctl_wait_t;

  // region view of the address word
  typedef struct packed {
    logic [15:0]             pad;
    logic [CTL_REGION_W-1:0] region;
    logic [CTL_OFFSET_W-1:0] offset;
  } ctl_adr_region_t;

  // port view, rows for the two read ports
  typedef struct packed {
    logic [15:0] pad;
    logic [1:0]  rd_type;
    logic [2:0]  rsvd_hi;
    ctl_row_t    r1_row;
    logic        rsvd_lo;
    ctl_row_t    r0_row;
  } ctl_adr_port_t;

  // one address word, decoded both ways
  typedef union packed {
    ctl_adr_region_t rgn;
    ctl_adr_port_t   prt;
  } ctl_adr_u;

  // host command, strobes last one cycle
  typedef struct packed {
    logic      ctl_val;
    logic      ra_val;
    logic      we;
    logic [3:0] sel;
    ctl_adr_u  adr;
    ctl_data_t dat;
  } ctl_cmd_t;

  // read return sources
  typedef enum logic [2:0] {
    SRC_R0   = 3'd0,
    SRC_R1   = 3'd1,
    SRC_LO   = 3'd2,
    SRC_HI   = 3'd3,
    SRC_CFG0 = 3'd4,
    SRC_BIST = 3'd5,
    SRC_ACFG = 3'd6
  } ctl_rd_src_e;

  // controls driven to the array
  typedef struct packed {
    logic      r0_enb;
    ctl_row_t  r0_adr;
    logic      r1_enb;
    ctl_row_t  r1_adr;
    logic      w0_enb;
    ctl_row_t  w0_adr;
    ctl_data_t w0_dat;
    logic      cfg_wr;
    ctl_data_t cfg_wdat;
    ctl_data_t bist_ctl;
  } ra_port_t;

  // data returned by the array
  typedef struct packed {
    ctl_data_t r0_dat;
    ctl_data_t r1_dat;
    ctl_data_t cfg_rdat;
    ctl_data_t bist_status;
  } ra_rsp_t;

endpackage

`default_nettype wire

// ==== ctl_read_seq.sv ====
// Read sequencer and return mux

`timescale 1ns/100ps
`default_nettype none

module ctl_read_seq
  import ctl_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        rd_start,
  input  ctl_rd_src_e rd_src,
  input  ctl_wait_t   rd_wait,
  input  ctl_data_t   cfg0_q,
  input  ra_rsp_t     ra_rsp,
  output logic        busy,
  output logic        rd_ack,
  output ctl_data_t   rd_dat
);

  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_WAIT = 1'b1
  } seq_state_e;

  seq_state_e  state_q;
  seq_state_e  state_d;
  ctl_wait_t   cnt_q;
  ctl_wait_t   cnt_d;
  ctl_rd_src_e src_q;
  logic        cnt_zero;
  ctl_data_t   sel_dat;

  assign cnt_zero = (cnt_q == '0);

  // next state and wait count
  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      ST_IDLE: begin
        // decoder already holds off starts while busy
        if (rd_start) begin
          state_d = ST_WAIT;
          cnt_d   = rd_wait;
        end
      end
      ST_WAIT: begin
        if (cnt_zero) begin
          state_d = ST_IDLE;
        end else begin
          cnt_d = cnt_q - 1'b1;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // source is latched with the start, held for the whole wait
  always_ff @(posedge clk) begin
    if (rd_start) begin
      src_q <= rd_src;
    end
  end

  // busy from the cycle after the strobe up to the ack
  assign busy   = (state_q == ST_WAIT);
  assign rd_ack = busy & cnt_zero;

  // return word by latched source
  always_comb begin
    case (src_q)
      SRC_R0:   sel_dat = ra_rsp.r0_dat;
      SRC_R1:   sel_dat = ra_rsp.r1_dat;
      // r1 half on top, r0 half below
      SRC_LO:   sel_dat = {ra_rsp.r1_dat[15:0], ra_rsp.r0_dat[15:0]};
      SRC_HI:   sel_dat = {ra_rsp.r1_dat[31:16], ra_rsp.r0_dat[31:16]};
      SRC_CFG0: sel_dat = cfg0_q;
      SRC_BIST: sel_dat = ra_rsp.bist_status;
      SRC_ACFG: sel_dat = ra_rsp.cfg_rdat;
      default:  sel_dat = '1;
    endcase
  end

  // data bus stays quiet outside the ack cycle
  assign rd_dat = rd_ack ? sel_dat : '0;

endmodule

`default_nettype wire

// ==== ctl_top.sv ====
// Command controller top level

`timescale 1ns/100ps
`default_nettype none

module ctl_top
  import ctl_pkg::*;
#(
  parameter logic [CTL_REGION_W-1:0] CFG_REGION  = 4'hE,
  parameter logic [CTL_REGION_W-1:0] BIST_REGION = 4'hF,
  parameter logic [CTL_OFFSET_W-1:0] CFG0_OFFSET = 12'h000,
  parameter ctl_data_t               CFG0_INIT   = 32'h0000_0001
) (
  input  logic      clk,
  input  logic      rst,
  input  ctl_cmd_t  cmd,
  input  ra_rsp_t   ra_rsp,
  output ra_port_t  ra_port,
  output logic      rd_ack,
  output ctl_data_t rd_dat
);

  logic        cfg0_we;
  ctl_data_t   cfg0_wdat;
  ctl_data_t   cfg0_q;
  ctl_wait_t   rd_wait;
  logic        rd_start;
  ctl_rd_src_e rd_src;
  logic        busy;

  // cfg0, holds the read wait count
  ctl_cfg_regs #(
    .CFG0_INIT (CFG0_INIT)
  ) cfg_regs_i (
    .clk       (clk),
    .rst       (rst),
    .cfg0_we   (cfg0_we),
    .cfg0_wdat (cfg0_wdat),
    .cfg0_q    (cfg0_q),
    .rd_wait   (rd_wait)
  );

  // strobe decode, array controls in the strobe cycle
  ctl_cmd_decode #(
    .CFG_REGION  (CFG_REGION),
    .BIST_REGION (BIST_REGION),
    .CFG0_OFFSET (CFG0_OFFSET)
  ) cmd_decode_i (
    .cmd       (cmd),
    .busy      (busy),
    .ra_port   (ra_port),
    .cfg0_we   (cfg0_we),
    .cfg0_wdat (cfg0_wdat),
    .rd_start  (rd_start),
    .rd_src    (rd_src)
  );

  // wait, then one-cycle ack with the selected word
  ctl_read_seq read_seq_i (
    .clk      (clk),
    .rst      (rst),
    .rd_start (rd_start),
    .rd_src   (rd_src),
    .rd_wait  (rd_wait),
    .cfg0_q   (cfg0_q),
    .ra_rsp   (ra_rsp),
    .busy     (busy),
    .rd_ack   (rd_ack),
    .rd_dat   (rd_dat)
  );

endmodule

`default_nettype wire

// ==== tb_ctl_top.sv ====
// Command controller testbench

`timescale 1ns/100ps
`default_nettype none

module tb_ctl_top
  import ctl_pkg::*;
();

  localparam logic [3:0]  CFG_REGION  = 4'hE;
  localparam logic [3:0]  BIST_REGION = 4'hF;
  localparam logic [11:0] CFG0_OFFSET = 12'h000;
  localparam ctl_data_t   CFG0_INIT   = 32'h0000_0001;
  // longest read is 1 + 7 wait cycles, plus margin
  localparam int ACK_LIMIT  = 12;
  // about 70 commands, each bounded by the ack limit and two idle cycles
  localparam int TIMEOUT_NS = (8 + 70 * (ACK_LIMIT + 2)) * 4;

  logic      clk = 1'b0;
  logic      rst;
  ctl_cmd_t  cmd;
  ra_port_t  ra_port;
  ra_rsp_t   ra_rsp;
  logic      rd_ack;
  ctl_data_t rd_dat;

  // expected array rows and cfg0
  ctl_data_t sb_rows [32];
  ctl_data_t sb_cfg0;
  ctl_row_t  wr_rows [8];
  int        cyc = 0;
  int        errors = 0;
  int        checks = 0;
  int        test_base = 0;
  integer    seed;

  always #2 clk = ~clk;

  // cycle index, sampled at the falling edge
  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  ctl_top #(
    .CFG_REGION  (CFG_REGION),
    .BIST_REGION (BIST_REGION),
    .CFG0_OFFSET (CFG0_OFFSET),
    .CFG0_INIT   (CFG0_INIT)
  ) ctl_top_i (
    .clk     (clk),
    .rst     (rst),
    .cmd     (cmd),
    .ra_rsp  (ra_rsp),
    .ra_port (ra_port),
    .rd_ack  (rd_ack),
    .rd_dat  (rd_dat)
  );

  ctl_array_model array_i (
    .clk     (clk),
    .rst     (rst),
    .ra_port (ra_port),
    .ra_rsp  (ra_rsp)
  );

  bind ctl_top ctl_checker checker_i (
    .clk     (clk),
    .rst     (rst),
    .rd_ack  (rd_ack),
    .busy    (busy),
    .ra_port (ra_port)
  );

  function automatic ctl_adr_u region_adr(input logic [3:0] region, input logic [11:0] offset);
    ctl_adr_u a;
    a            = '0;
    a.rgn.region = region;
    a.rgn.offset = offset;
    return a;
  endfunction

  // upper rsvd bits stay zero so the region never looks special
  function automatic ctl_adr_u port_adr(input logic [1:0] rd_type, input ctl_row_t r0,
                                        input ctl_row_t r1);
    ctl_adr_u a;
    a             = '0;
    a.prt.rd_type = rd_type;
    a.prt.r0_row  = r0;
    a.prt.r1_row  = r1;
    return a;
  endfunction

  function automatic ctl_cmd_t make_cmd(input logic to_ctl, input logic we,
                                        input logic [3:0] sel, input ctl_adr_u adr,
                                        input ctl_data_t dat);
    ctl_cmd_t c;
    c         = '0;
    c.ctl_val = to_ctl;
    c.ra_val  = ~to_ctl;
    c.we      = we;
    c.sel     = sel;
    c.adr     = adr;
    c.dat     = dat;
    return c;
  endfunction

  task automatic check_data(input string sig, input ctl_data_t got, input ctl_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s got %08h exp %08h", sig, got, exp);
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("ERROR rd_ack cycle got N+%0h exp N+%0h", got, exp);
    end
  endtask

  // one strobe cycle, then idle
  task automatic issue_write(input ctl_cmd_t c);
    @(negedge clk);
    cmd = c;
    @(negedge clk);
    cmd = '0;
  endtask

  // ack due in cycle N+1+W, W taken from cfg0 at the strobe
  task automatic issue_read(input ctl_cmd_t c, input ctl_data_t exp);
    int start;
    @(negedge clk);
    cmd   = c;
    start = cyc;
    @(negedge clk);
    cmd = '0;
    while (!rd_ack && (cyc - start) <= ACK_LIMIT)
      @(negedge clk);
    if (!rd_ack) begin
      errors++;
      $display("no read acknowledge within %0d cycles", ACK_LIMIT);
    end else begin
      check_latency(cyc - start, 1 + int'(sb_cfg0[CTL_WAIT_W-1:0]));
      check_data("rd_dat", rd_dat, exp);
      @(negedge clk);
      // data bus back to zero after the ack
      check_data("rd_dat", rd_dat, '0);
    end
  endtask

  task automatic set_wait(input ctl_wait_t w);
    issue_write(make_cmd(1'b1, 1'b1, 4'h0, region_adr(4'h0, CFG0_OFFSET), 32'(w)));
    sb_cfg0 = 32'(w);
  endtask

  task automatic write_row(input ctl_row_t row, input ctl_data_t dat);
    issue_write(make_cmd(1'b0, 1'b1, 4'h1, port_adr(2'b00, row, '0), dat));
    sb_rows[row] = dat;
  endtask

  task automatic port_read(input logic [1:0] rd_type, input ctl_row_t r0, input ctl_row_t r1);
    ctl_data_t d0;
    ctl_data_t d1;
    ctl_data_t exp;
    d0 = sb_rows[r0];
    d1 = sb_rows[r1];
    case (rd_type)
      // type 01 reads the r0 row through port 1
      2'b00, 2'b01: exp = d0;
      2'b10:        exp = {d1[15:0], d0[15:0]};
      default:      exp = {d1[31:16], d0[31:16]};
    endcase
    issue_read(make_cmd(1'b0, 1'b0, 4'h0, port_adr(rd_type, r0, r1), '0), exp);
  endtask

  task automatic target_read(input logic to_ctl, input logic [3:0] region, input ctl_data_t exp);
    issue_read(make_cmd(to_ctl, 1'b0, 4'h0, region_adr(region, CFG0_OFFSET), '0), exp);
  endtask

  task automatic finish_test(input string name);
    if (errors == test_base) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - test_base);
    end
    test_base = errors;
  endtask

  task automatic reset_and_wait();
    target_read(1'b1, 4'h0, CFG0_INIT);
    set_wait(3'd5);
    target_read(1'b1, 4'h0, 32'd5);
    finish_test("reset_and_wait");
  endtask

  task automatic row_single_reads();
    ctl_row_t base;
    base = ctl_row_t'($random(seed));
    // step of 5 keeps the eight rows distinct
    for (int i = 0; i < 8; i++) begin
      wr_rows[i] = base + ctl_row_t'(5 * i);
      write_row(wr_rows[i], ctl_data_t'($random(seed)));
    end
    for (int i = 0; i < 8; i++) begin
      set_wait(ctl_wait_t'(i));
      port_read(2'b00, wr_rows[i], wr_rows[7 - i]);
      port_read(2'b01, wr_rows[i], wr_rows[7 - i]);
    end
    finish_test("row_single_reads");
  endtask

  task automatic dual_port_merge();
    set_wait(3'd2);
    for (int i = 0; i < 4; i++) begin
      port_read(2'b10, wr_rows[i], wr_rows[i + 4]);
      port_read(2'b11, wr_rows[i], wr_rows[i + 4]);
    end
    finish_test("dual_port_merge");
  endtask

  task automatic special_regions();
    ctl_data_t d;
    ctl_data_t acfg;
    ctl_row_t  row;
    row = wr_rows[0];
    set_wait(3'd1);
    // offset aliases a written row, which must stay as it is
    acfg = ctl_data_t'($random(seed));
    issue_write(make_cmd(1'b0, 1'b1, 4'hf, region_adr(CFG_REGION, 12'(row)), acfg));
    target_read(1'b1, CFG_REGION, acfg);
    target_read(1'b0, CFG_REGION, acfg);
    d = ctl_data_t'($random(seed)) | 32'h1;
    issue_write(make_cmd(1'b0, 1'b1, 4'hf, region_adr(BIST_REGION, 12'(row)), d));
    target_read(1'b1, BIST_REGION, ~d);
    target_read(1'b0, BIST_REGION, ~d);
    // self-test write leaves the array config alone
    target_read(1'b1, CFG_REGION, acfg);
    // plain row write carries no self-test word and no config strobe
    write_row(wr_rows[1], ctl_data_t'($random(seed)));
    target_read(1'b0, BIST_REGION, ~d);
    target_read(1'b0, CFG_REGION, acfg);
    // ctl write into a special region leaves cfg0 unchanged
    issue_write(make_cmd(1'b1, 1'b1, 4'hf, region_adr(CFG_REGION, CFG0_OFFSET), 32'h7));
    target_read(1'b1, 4'h0, sb_cfg0);
    for (int i = 0; i < 8; i++) begin
      port_read(2'b00, wr_rows[i], wr_rows[i]);
    end
    finish_test("special_regions");
  endtask

  task automatic busy_drop();
    int        start;
    int        acks;
    int        lat;
    ctl_data_t got;
    acks = 0;
    lat  = 0;
    got  = '0;
    set_wait(3'd4);
    @(negedge clk);
    cmd   = make_cmd(1'b0, 1'b0, 4'h0, port_adr(2'b00, wr_rows[1], '0), '0);
    start = cyc;
    @(negedge clk);
    // second read arrives while busy and is lost
    // a merge read would touch both ports and change the source
    cmd = make_cmd(1'b0, 1'b0, 4'h0, port_adr(2'b10, wr_rows[2], wr_rows[3]), '0);
    @(negedge clk);
    cmd = '0;
    // listen for a second ack as well
    repeat (ACK_LIMIT) begin
      if (rd_ack) begin
        acks++;
        got = rd_dat;
        lat = cyc - start;
      end
      @(negedge clk);
    end
    if (acks != 1) begin
      errors++;
      $display("expected exactly one read acknowledge, saw %0d", acks);
    end else begin
      check_latency(lat, 1 + int'(sb_cfg0[CTL_WAIT_W-1:0]));
      check_data("rd_dat", got, sb_rows[wr_rows[1]]);
    end
    finish_test("busy_drop");
  endtask

  initial begin
    seed    = 32'he91b_5da0;
    cmd     = '0;
    rst     = 1'b1;
    sb_cfg0 = CFG0_INIT;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    reset_and_wait();
    row_single_reads();
    dual_port_merge();
    special_regions();
    busy_drop();
    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // bound to the expected length of all tests
  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns, run did not finish", TIMEOUT_NS);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
ctl_pkg.sv
ctl_cfg_regs.sv
ctl_cmd_decode.sv
ctl_read_seq.sv
ctl_top.sv
ctl_array_model.sv
ctl_checker.sv
tb_ctl_top.sv
